// File: files.f
+incdir+verilog
verilog/shell_pkg.sv
verilog/host_ctrl_if.sv
verilog/user_io.sv
verilog/ps2_keyboard.sv
verilog/control_merge.sv
verilog/mono_video_out.sv
verilog/sigma_delta_dac.sv
verilog/arcade_shell.sv
dv/shell_checker.sv
dv/tb_arcade_shell.sv

// File: run_sim.sh
#!/bin/sh
# Build the shell testbench with Verilator, run it and scan the log for failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_arcade_shell -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// File: dv/tb_arcade_shell.sv
// Shell testbench: clock, reset and random host, keyboard, video and audio stimulus.
`timescale 1ns/10ps
`include "shell_defines.svh"

module tb_arcade_shell;
	import shell_pkg::*;

	logic       clk_sys = 1'b0;
	logic       reset = 1'b1;
	logic       spi_sck = 1'b0;
	logic       spi_ss2 = 1'b1;
	logic       spi_di = 1'b0;
	logic       spi_do;
	logic       ps2_kbd_clk = 1'b1;
	logic       ps2_kbd_data = 1'b1;
	video_lvl_t video = '0;
	logic       hsync = 1'b1;
	logic       vsync = 1'b1;
	audio_t     audio1 = '0;
	audio_t     audio2 = '0;
	rgb_t       vga_r, vga_g, vga_b;
	logic       vga_hs, vga_vs, audio_l, audio_r;
	logic       fire1_n, start1_n, coin1_n, slam_n, test_n, core_reset_n;
	int         errors;
	logic       settled;
	int         windows;
	int         err_base = 0;
	int         tests = 0;

	arcade_shell i_arcade_shell (.*);

	shell_checker i_shell_checker (.*);

	initial begin
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic end_run(input bit timed_out);
		$display("tests run: %0d, errors: %0d", tests, errors);
		if (!timed_out && errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic phase();
		repeat (4 + $urandom % 3) @(negedge clk_sys);
	endtask

	task automatic wait_settled();
		int n;
		n = 0;
		while (!settled) begin
			@(negedge clk_sys);
			n = n + 1;
			if (n > 200) begin
				$display("timeout: control outputs never settled after a frame");
				end_run(1'b1);
			end
		end
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic spi_send(input spi_byte_t b);
		for (int i = 7; i >= 0; i--) begin
			spi_di = b[i];
			phase();
			spi_sck = 1'b1;
			phase();
			spi_sck = 1'b0;
		end
	endtask

	task automatic spi_write(input spi_byte_t cmd, input status_t data, input int nbytes);
		spi_ss2 = 1'b0;
		phase();
		spi_send(cmd);
		for (int i = 0; i < nbytes; i++) begin
			spi_send(data[8 * i +: 8]);
		end
		phase();
		spi_ss2 = 1'b1;
		wait_settled();
	endtask

	task automatic ps2_send(input spi_byte_t code, input bit good);
		logic [10:0] frame;
		frame = {1'b1, ~(^code) ^ ~good, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_kbd_data = frame[i];
			phase();
			ps2_kbd_clk = 1'b0;
			phase();
			ps2_kbd_clk = 1'b1;
		end
		ps2_kbd_data = 1'b1;
		wait_settled();
	endtask

	task automatic finish_test(input string name);
		tests = tests + 1;
		$display("test %0d %s: %0d errors", tests, name, errors - err_base);
		err_base = errors;
	endtask

	initial begin
		logic [31:0] r;
		spi_byte_t   codes [5];
		int          n;
		int          win_base;
		void'($urandom(86));
		codes = '{`KEY_FIRE, `KEY_START1, `KEY_START2, `KEY_COIN, 8'h1C};
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		repeat (12) @(negedge clk_sys);

		for (int i = 0; i < 30; i++) begin
			r = $urandom;
			case (r[2:0])
				3'd0: spi_write(`CMD_BUTTONS, $urandom, 1);
				3'd1: spi_write(`CMD_JOY0, $urandom, 1);
				3'd2: spi_write(`CMD_JOY1, $urandom, 1);
				3'd3, 3'd4: spi_write(`CMD_STATUS, $urandom, 4);
				default: spi_write(8'h55, $urandom, 2);           // unknown command.
			endcase
		end
		finish_test("host settings");

		for (int i = 0; i < 8; i++) begin
			spi_write(8'h40 + 8'(i), 32'd0, 1);
		end
		finish_test("core id");

		spi_write(`CMD_STATUS, 32'd0, 4);
		spi_write(`CMD_BUTTONS, 32'd0, 1);
		for (int i = 0; i < 40; i++) begin
			r = $urandom;
			if (r[4:3] == 2'd0) begin
				spi_write(r[5] ? `CMD_JOY1 : `CMD_JOY0, {27'd0, r[6], 4'd0}, 1);
			end
			if (r[0]) begin
				ps2_send(`KEY_BREAK, r[9:7] != 3'd0);
			end
			ps2_send(codes[r[12:10] % 5], r[15:13] != 3'd0);
		end
		finish_test("keyboard and fire");

		for (int mode = 0; mode < 4; mode++) begin
			spi_write(`CMD_STATUS, 32'(mode) << 3, 4);
			for (int c = 0; c < 300; c++) begin
				r = $urandom;
				@(negedge clk_sys);
				video = r[1:0];
				hsync = (c % 20) >= 3;                            // 3 cycle pulse per 20.
				if (r[9:4] == 6'd0) begin
					vsync = ~vsync;
				end
			end
			hsync = 1'b1;
			vsync = 1'b1;
		end
		finish_test("video");

		for (int i = 0; i < 4; i++) begin
			r = $urandom;
			while ({r[6:0], r[13:7]} == {audio1, audio2}) begin
				r = $urandom;                                     // a new value opens a window.
			end
			win_base = windows;
			n        = 0;
			audio1   = r[6:0];
			audio2   = r[13:7];
			while (windows == win_base) begin
				@(negedge clk_sys);
				n = n + 1;
				if (n > 3000) begin
					$display("timeout: audio window did not complete");
					end_run(1'b1);
				end
			end
		end
		finish_test("audio");
		end_run(1'b0);
	end

endmodule

// File: dv/shell_checker.sv
// Shell checker: models host, keyboard, control, video and audio rules and compares the DUT.
`timescale 1ns/10ps
`include "shell_defines.svh"

module shell_checker
	import shell_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       spi_sck,
	input  logic       spi_ss2,
	input  logic       spi_di,
	input  logic       spi_do,
	input  logic       ps2_kbd_clk,
	input  logic       ps2_kbd_data,
	input  video_lvl_t video,
	input  logic       hsync,
	input  logic       vsync,
	input  audio_t     audio1,
	input  audio_t     audio2,
	input  rgb_t       vga_r,
	input  rgb_t       vga_g,
	input  rgb_t       vga_b,
	input  logic       vga_hs,
	input  logic       vga_vs,
	input  logic       audio_l,
	input  logic       audio_r,
	input  logic       fire1_n,
	input  logic       start1_n,
	input  logic       coin1_n,
	input  logic       slam_n,
	input  logic       test_n,
	input  logic       core_reset_n,
	output int         errors,
	output logic       settled,
	output int         windows
);

	localparam spi_byte_t core_id = `SHELL_CORE_ID;

	rgb_t        lvl_full [4] = '{6'h00, 6'h15, 6'h2A, 6'h3F};
	rgb_t        lvl_q75  [4] = '{6'h00, 6'h10, 6'h20, 6'h30};   // level minus a quarter.
	rgb_t        lvl_half [4] = '{6'h00, 6'h0A, 6'h15, 6'h1F};
	status_t     m_status = '0;
	joy_t        m_joy0 = '0;
	joy_t        m_joy1 = '0;
	logic [1:0]  m_btn = '0;
	logic [23:0] m_shadow = '0;
	spi_byte_t   m_cmd = '0;
	spi_byte_t   m_sr = '0;
	int          m_bit = 0;
	int          m_byte = 0;
	logic        sck_prev = 1'b0;
	logic        ss_prev = 1'b1;
	int          spi_errors = 0;
	key_vec_t    m_keys = '0;
	logic        m_brk = 1'b0;
	logic [10:0] p_bits = '0;
	int          p_cnt = 0;
	logic [5:0]  exp_ctrl;
	logic [7:0]  last_ctrl = '0;          // scanline mode sits above the controls.
	int          stable = 0;
	int          since_rst = 0;
	logic        in_reset = 1'b0;
	logic        hs_prev = 1'b1;
	logic        odd = 1'b0;
	logic        vid_valid = 1'b0;
	rgb_t        exp_rgb;
	logic        exp_hs;
	logic        exp_vs;
	dac_word_t   dac_last = '0;
	int          aud_gen = 0;
	int          seen_gen = 0;
	int          a_cnt = 0;
	int          a_ones = 0;
	int          edge_errors = 0;
	int          win_cnt = 0;

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
	endtask

	// host side: spi_do is checked where the host samples it.
	always @(spi_sck or spi_ss2) begin
		logic exp_do;
		if (ss_prev && !spi_ss2) begin
			m_bit  = 0;
			m_byte = 0;
		end
		if (spi_sck && !sck_prev && !spi_ss2) begin
			exp_do = (m_byte == 0) ? core_id[7 - m_bit] : 1'b0;   // id only in the command byte.
			if (spi_do !== exp_do) begin
				mismatch("spi_do", {31'd0, exp_do}, {31'd0, spi_do});
				spi_errors = spi_errors + 1;
			end
			m_sr  = {m_sr[6:0], spi_di};
			m_bit = m_bit + 1;
			if (m_bit == 8) begin
				m_bit = 0;
				if (m_byte == 0) begin
					m_cmd = m_sr;
				end else if (m_cmd == `CMD_BUTTONS && m_byte == 1) begin
					m_btn = m_sr[1:0];
				end else if (m_cmd == `CMD_JOY0 && m_byte == 1) begin
					m_joy0 = m_sr;
				end else if (m_cmd == `CMD_JOY1 && m_byte == 1) begin
					m_joy1 = m_sr;
				end else if (m_cmd == `CMD_STATUS && m_byte < 4) begin
					m_shadow[8 * (m_byte - 1) +: 8] = m_sr;
				end else if (m_cmd == `CMD_STATUS && m_byte == 4) begin
					m_status = {m_sr, m_shadow};
				end
				m_byte = m_byte + 1;
			end
		end
		sck_prev = spi_sck;
		ss_prev  = spi_ss2;
	end

	// keyboard frames: start, 8 data bits, parity, stop.
	always @(negedge ps2_kbd_clk) begin
		if (p_cnt != 0 || !ps2_kbd_data) begin
			p_bits = {ps2_kbd_data, p_bits[10:1]};
			p_cnt  = p_cnt + 1;
		end
		if (p_cnt == 11) begin
			p_cnt = 0;
			if (!p_bits[10] || !(^p_bits[9:1])) begin
				m_brk = 1'b0;
			end else if (p_bits[8:1] == `KEY_BREAK) begin
				m_brk = 1'b1;
			end else begin
				case (p_bits[8:1])
					`KEY_FIRE:   m_keys[0] = ~m_brk;
					`KEY_START1: m_keys[1] = ~m_brk;
					`KEY_START2: m_keys[2] = ~m_brk;
					`KEY_COIN:   m_keys[3] = ~m_brk;
					default: ;
				endcase
				m_brk = 1'b0;
			end
		end
	end

	always_comb begin
		exp_ctrl[5] = ~(m_keys[0] | m_joy0[4] | m_joy1[4]);
		exp_ctrl[4] = ~(m_keys[1] | m_keys[2]);
		exp_ctrl[3] = ~m_keys[3];
		exp_ctrl[2] = ~m_status[2];
		exp_ctrl[1] = ~m_status[1];
		exp_ctrl[0] = ~(m_status[0] | m_status[6] | m_btn[1]);
	end

	assign settled = (stable >= 10);
	assign errors  = spi_errors + edge_errors;
	assign windows = win_cnt;

	// inputs are stable at the rising edge, outputs are compared at the falling edge.
	always @(posedge clk_sys) begin
		stable    = ({m_status[4:3], exp_ctrl} != last_ctrl) ? 0 :
			((stable < 1000) ? stable + 1 : stable);
		last_ctrl = {m_status[4:3], exp_ctrl};
		in_reset  = reset;
		if (reset) begin
			since_rst = 0;
			hs_prev   = 1'b1;
			odd       = 1'b0;
			vid_valid = 1'b0;
		end else begin
			since_rst = (since_rst < 1000) ? since_rst + 1 : since_rst;
			exp_rgb   = lvl_full[video];
			if (odd && m_status[4:3] == 2'd2) begin
				exp_rgb = lvl_q75[video];
			end else if (odd && m_status[4:3] == 2'd3) begin
				exp_rgb = lvl_half[video];
			end
			exp_hs    = hsync;
			exp_vs    = vsync;
			vid_valid = (stable >= 10);
			if (hs_prev && !hsync) begin
				odd = ~odd;
			end
			hs_prev = hsync;
		end
		if ({audio1, audio2, 2'b00} != dac_last) begin
			dac_last = {audio1, audio2, 2'b00};
			aud_gen  = aud_gen + 1;
		end
	end

	always @(negedge clk_sys) begin
		int         d;
		logic [5:0] act_ctrl;
		act_ctrl = {fire1_n, start1_n, coin1_n, slam_n, test_n, core_reset_n};
		if (in_reset && act_ctrl !== 6'b111110) begin
			mismatch("reset controls", {26'd0, 6'b111110}, {26'd0, act_ctrl});   // core held.
			edge_errors = edge_errors + 1;
		end
		if (since_rst >= 2) begin
			if (stable >= 10 && act_ctrl !== exp_ctrl) begin
				mismatch("controls", {26'd0, exp_ctrl}, {26'd0, act_ctrl});
				edge_errors = edge_errors + 1;
			end
			if (vid_valid && {vga_r, vga_g, vga_b} !== {exp_rgb, exp_rgb, exp_rgb}) begin
				mismatch("vga_rgb", {14'd0, exp_rgb, exp_rgb, exp_rgb},
					{14'd0, vga_r, vga_g, vga_b});
				edge_errors = edge_errors + 1;
			end
			if (vid_valid && {vga_hs, vga_vs} !== {exp_hs, exp_vs}) begin
				mismatch("vga_hs_vs", {30'd0, exp_hs, exp_vs}, {30'd0, vga_hs, vga_vs});
				edge_errors = edge_errors + 1;
			end
		end
		if (audio_r !== audio_l) begin
			mismatch("audio_r", {31'd0, audio_l}, {31'd0, audio_r});
			edge_errors = edge_errors + 1;
		end
		if (seen_gen != aud_gen) begin
			seen_gen = aud_gen;
			a_cnt    = 0;
			a_ones   = 0;
		end
		if (aud_gen != 0 && a_cnt < 2048) begin
			a_cnt  = a_cnt + 1;
			a_ones = a_ones + (audio_l ? 1 : 0);
			if (a_cnt == 2048) begin
				d = int'(dac_last);
				if (a_ones * 32 - d > 32 || d - a_ones * 32 > 32) begin
					mismatch("audio_l ones", d / 32, a_ones);   // count per 2048 cycles.
					edge_errors = edge_errors + 1;
				end
				win_cnt = win_cnt + 1;
			end
		end
	end

endmodule

// File: verilog/arcade_shell.sv
// Arcade platform shell: host SPI, keyboard, control merge, video output and audio DAC.
`timescale 1ns/10ps

module arcade_shell
	import shell_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       spi_sck,
	input  logic       spi_ss2,
	input  logic       spi_di,
	output logic       spi_do,
	input  logic       ps2_kbd_clk,
	input  logic       ps2_kbd_data,
	input  video_lvl_t video,
	input  logic       hsync,
	input  logic       vsync,
	input  audio_t     audio1,
	input  audio_t     audio2,
	output rgb_t       vga_r,
	output rgb_t       vga_g,
	output rgb_t       vga_b,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       audio_l,
	output logic       audio_r,
	output logic       fire1_n,
	output logic       start1_n,
	output logic       coin1_n,
	output logic       slam_n,
	output logic       test_n,
	output logic       core_reset_n
);

	key_vec_t       keys;
	scanline_mode_t scanline;
	dac_word_t      dac_in;

	host_ctrl_if ctrl_if ();

	assign dac_in  = {audio1, audio2, 2'b00};     // both channels mixed into one word.
	assign audio_r = audio_l;

	user_io i_user_io (
		.clk_sys (clk_sys),
		.reset   (reset),
		.spi_sck (spi_sck),
		.spi_ss2 (spi_ss2),
		.spi_di  (spi_di),
		.spi_do  (spi_do),
		.ctrl    (ctrl_if.host)
	);

	ps2_keyboard i_ps2_keyboard (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.keys         (keys)
	);

	control_merge i_control_merge (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ctrl         (ctrl_if.merge),
		.keys         (keys),
		.fire1_n      (fire1_n),
		.start1_n     (start1_n),
		.coin1_n      (coin1_n),
		.slam_n       (slam_n),
		.test_n       (test_n),
		.core_reset_n (core_reset_n),
		.scanline     (scanline)
	);

	mono_video_out i_mono_video_out (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.video    (video),
		.hsync    (hsync),
		.vsync    (vsync),
		.scanline (scanline),
		.vga_r    (vga_r),
		.vga_g    (vga_g),
		.vga_b    (vga_b),
		.vga_hs   (vga_hs),
		.vga_vs   (vga_vs)
	);

	sigma_delta_dac i_sigma_delta_dac (
		.clk_sys (clk_sys),
		.reset   (reset),
		.din     (dac_in),
		.dout    (audio_l)
	);

endmodule

// File: verilog/sigma_delta_dac.sv
// Audio DAC: first-order sigma-delta modulator with a one-bit output.
`timescale 1ns/10ps

module sigma_delta_dac
	import shell_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  dac_word_t din,
	output logic      dout
);

	dac_word_t   acc;
	logic [16:0] sum;

	assign sum = {1'b0, acc} + {1'b0, din};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc  <= '0;
			dout <= 1'b0;
		end else begin
			acc  <= sum[15:0];
			dout <= sum[16];                        // overflow is the pulse density.
		end
	end

endmodule

// File: verilog/mono_video_out.sv
// Monochrome video output: level to 6-bit RGB with scanline dimming and matched syncs.
`timescale 1ns/10ps

module mono_video_out
	import shell_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,
	input  video_lvl_t     video,
	input  logic           hsync,
	input  logic           vsync,
	input  scanline_mode_t scanline,
	output rgb_t           vga_r,
	output rgb_t           vga_g,
	output rgb_t           vga_b,
	output logic           vga_hs,
	output logic           vga_vs
);

	rgb_t level_rgb;
	rgb_t dim_rgb;
	logic odd_line;

	assign level_rgb = {video, video, video};     // 00, 15, 2a, 3f.

	always_comb begin
		dim_rgb = level_rgb;
		if (odd_line) begin
			case (scanline)
				SL_25:   dim_rgb = level_rgb - (level_rgb >> 2);
				SL_50:   dim_rgb = level_rgb >> 1;
				default: dim_rgb = level_rgb;       // hq2x behaves like none.
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vga_hs   <= 1'b1;
			vga_vs   <= 1'b1;
			odd_line <= 1'b0;
		end else begin
			vga_hs <= hsync;
			vga_vs <= vsync;
			if (vga_hs && !hsync) begin
				odd_line <= ~odd_line;               // new line at falling hsync.
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		vga_r <= dim_rgb;
		vga_g <= dim_rgb;
		vga_b <= dim_rgb;
	end

endmodule

// File: verilog/control_merge.sv
// Control merge: active-low game inputs and core reset from keys, joysticks and status.
`timescale 1ns/10ps

module control_merge
	import shell_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,
	host_ctrl_if.merge     ctrl,
	input  key_vec_t       keys,
	output logic           fire1_n,
	output logic           start1_n,
	output logic           coin1_n,
	output logic           slam_n,
	output logic           test_n,
	output logic           core_reset_n,
	output scanline_mode_t scanline
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fire1_n      <= 1'b1;
			start1_n     <= 1'b1;
			coin1_n      <= 1'b1;
			slam_n       <= 1'b1;
			test_n       <= 1'b1;
			core_reset_n <= 1'b0;                   // core held while the shell resets.
			scanline     <= SL_NONE;
		end else begin
			fire1_n      <= ~(keys[0] | ctrl.joystick_0[4] | ctrl.joystick_1[4]);
			start1_n     <= ~(keys[1] | keys[2]);    // either start key starts player 1.
			coin1_n      <= ~keys[3];
			slam_n       <= ~ctrl.status[2];
			test_n       <= ~ctrl.status[1];
			core_reset_n <= ~(ctrl.status[0] | ctrl.status[6] | ctrl.buttons[1]);
			scanline     <= scanline_mode_t'(ctrl.status[4:3]);
		end
	end

endmodule

// File: verilog/ps2_keyboard.sv
// PS/2 keyboard receiver: checks frames and maps scan codes onto the game keys.
`timescale 1ns/10ps
`include "shell_defines.svh"

module ps2_keyboard
	import shell_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     ps2_kbd_clk,
	input  logic     ps2_kbd_data,
	output key_vec_t keys
);

	logic [1:0] clk_q;
	logic       data_q;
	logic       clk_fall;
	logic       frame_ok;
	ps2_state_t state;
	logic [2:0] bit_cnt;
	logic [7:0] code;
	logic       parity;
	logic       brk;

	assign clk_fall = clk_q[1] & ~clk_q[0];
	assign frame_ok = data_q & (^{code, parity});   // stop bit high, odd parity.

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clk_q  <= '1;
			data_q <= 1'b1;
		end else begin
			clk_q  <= {clk_q[0], ps2_kbd_clk};
			data_q <= ps2_kbd_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (clk_fall && state == DATA) begin
			code <= {data_q, code[7:1]};             // lsb arrives first.
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= IDLE;
			bit_cnt <= '0;
			parity  <= 1'b0;
			brk     <= 1'b0;
			keys    <= '0;
		end else if (clk_fall) begin
			case (state)
				IDLE: begin
					if (!data_q) begin
						state   <= DATA;
						bit_cnt <= '0;
					end
				end
				DATA: begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						state <= PARITY;
					end
				end
				PARITY: begin
					parity <= data_q;
					state  <= STOP;
				end
				STOP: begin
					state <= IDLE;
					if (!frame_ok) begin
						brk <= 1'b0;                     // bad frame also loses its prefix.
					end else if (code == `KEY_BREAK) begin
						brk <= 1'b1;
					end else begin
						brk <= 1'b0;
						case (code)
							`KEY_FIRE:   keys[0] <= ~brk;
							`KEY_START1: keys[1] <= ~brk;
							`KEY_START2: keys[2] <= ~brk;
							`KEY_COIN:   keys[3] <= ~brk;
							default: ;
						endcase
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: verilog/user_io.sv
// Host SPI slave: decodes commands, holds status, joysticks and buttons, answers with core ID.
`timescale 1ns/10ps
`include "shell_defines.svh"

module user_io
	import shell_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      spi_sck,
	input  logic      spi_ss2,
	input  logic      spi_di,
	output logic      spi_do,
	host_ctrl_if.host ctrl
);

	localparam spi_byte_t core_id = `SHELL_CORE_ID;

	logic [2:0]  sck_q;
	logic [2:0]  ss_q;
	logic [1:0]  di_q;
	logic        sck_rise;
	logic        sck_fall;
	logic        ss_active;
	logic        ss_fall;
	logic        byte_done;
	logic [2:0]  bit_cnt;
	logic [2:0]  byte_cnt;
	logic [6:0]  sr;
	spi_byte_t   rx_byte;
	spi_byte_t   cmd;
	logic [23:0] status_shadow;
	status_t     status_q;
	joy_t        joy0_q;
	joy_t        joy1_q;
	logic [1:0]  buttons_q;

	assign sck_rise  = sck_q[1] & ~sck_q[2];
	assign sck_fall  = ~sck_q[1] & sck_q[2];
	assign ss_active = ~ss_q[1];
	assign ss_fall   = ~ss_q[1] & ss_q[2];
	assign rx_byte   = {sr, di_q[1]};          // byte completed by the current bit.
	assign byte_done = ss_active & sck_rise & (bit_cnt == 3'd7);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sck_q <= '0;
			ss_q  <= '1;
			di_q  <= '0;
		end else begin
			sck_q <= {sck_q[1:0], spi_sck};
			ss_q  <= {ss_q[1:0], spi_ss2};
			di_q  <= {di_q[0], spi_di};
		end
	end

	// counters restart with every frame.
	always_ff @(posedge clk_sys) begin
		if (reset || !ss_active) begin
			bit_cnt  <= '0;
			byte_cnt <= '0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7 && byte_cnt != 3'd7) begin
				byte_cnt <= byte_cnt + 3'd1;      // saturates.
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sck_rise) begin
			sr <= rx_byte[6:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_done && cmd == `CMD_STATUS) begin
			case (byte_cnt)
				3'd1: status_shadow[7:0]   <= rx_byte;
				3'd2: status_shadow[15:8]  <= rx_byte;
				3'd3: status_shadow[23:16] <= rx_byte;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd       <= '0;
			status_q  <= '0;
			joy0_q    <= '0;
			joy1_q    <= '0;
			buttons_q <= '0;
		end else if (byte_done) begin
			if (byte_cnt == 3'd0) begin
				cmd <= rx_byte;
			end else begin
				case (cmd)
					`CMD_BUTTONS: if (byte_cnt == 3'd1) buttons_q <= rx_byte[1:0];
					`CMD_JOY0:    if (byte_cnt == 3'd1) joy0_q <= rx_byte;
					`CMD_JOY1:    if (byte_cnt == 3'd1) joy1_q <= rx_byte;
					`CMD_STATUS:  if (byte_cnt == 3'd4) status_q <= {rx_byte, status_shadow};
					default: ;
				endcase
			end
		end
	end

	// core ID goes out MSB first, one bit per falling sck.
	always_ff @(posedge clk_sys) begin
		if (reset || !ss_active) begin
			spi_do <= 1'b0;
		end else if (ss_fall) begin
			spi_do <= core_id[7];
		end else if (sck_fall) begin
			spi_do <= (byte_cnt == 3'd0) ? core_id[3'd7 - bit_cnt] : 1'b0;
		end
	end

	assign ctrl.status     = status_q;
	assign ctrl.joystick_0 = joy0_q;
	assign ctrl.joystick_1 = joy1_q;
	assign ctrl.buttons    = buttons_q;

endmodule

// File: verilog/host_ctrl_if.sv
// Host settings bus: status word, joysticks and board buttons from the SPI receiver.
`timescale 1ns/10ps

interface host_ctrl_if
	import shell_pkg::*;
();

	status_t    status;
	joy_t       joystick_0;
	joy_t       joystick_1;
	logic [1:0] buttons;

	modport host (
		output status, joystick_0, joystick_1, buttons
	);

	modport merge (
		input status, joystick_0, joystick_1, buttons
	);

endinterface

// File: verilog/shell_pkg.sv
// Shell types: bus widths and state encodings shared by the platform shell.
package shell_pkg;

	typedef logic [7:0]  spi_byte_t;
	typedef logic [7:0]  joy_t;       // bit 4 is fire.
	typedef logic [31:0] status_t;
	typedef logic [3:0]  key_vec_t;   // fire, start 1, start 2, coin from bit 0 up.
	typedef logic [1:0]  video_lvl_t;
	typedef logic [5:0]  rgb_t;
	typedef logic [6:0]  audio_t;
	typedef logic [15:0] dac_word_t;

	// decoded from status bits 4:3.
	typedef enum logic [1:0] {
		SL_NONE = 2'd0,
		SL_HQ2X = 2'd1,
		SL_25   = 2'd2,
		SL_50   = 2'd3
	} scanline_mode_t;

	typedef enum logic [1:0] {
		IDLE,
		DATA,
		PARITY,
		STOP
	} ps2_state_t;

endpackage

// File: verilog/shell_defines.svh
// Shell constants: core identifier, host SPI command codes and PS/2 scan codes.
`ifndef SHELL_DEFINES_SVH
`define SHELL_DEFINES_SVH

// identifier returned to the host during each command byte.
`define SHELL_CORE_ID 8'hA4

// host SPI commands.
`define CMD_BUTTONS 8'h01
`define CMD_JOY0    8'h02
`define CMD_JOY1    8'h03
`define CMD_STATUS  8'h1E

// set 2 scan codes for the game keys.
`define KEY_FIRE    8'h29
`define KEY_START1  8'h16
`define KEY_START2  8'h1E
`define KEY_COIN    8'h2E
`define KEY_BREAK   8'hF0

`endif
